// File: Bender.yml
package:
  name: rv_core_backend

sources:
  - verilog/rv_pkg.sv
  - verilog/rv_regfile.sv
  - verilog/rv_decode.sv
  - verilog/rv_execute.sv
  - verilog/rv_mem_access.sv
  - verilog/rv_data_mem.sv
  - verilog/rv_core_top.sv
  - target: test
    files:
      - verif/rv_core_properties.sv
      - verif/rv_core_tb.sv

// File: project.f
verilog/rv_pkg.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_mem_access.sv
verilog/rv_data_mem.sv
verilog/rv_core_top.sv
verif/rv_core_properties.sv
verif/rv_core_tb.sv

// File: verif/rv_core_properties.sv
`default_nettype none
`timescale 1ns/100ps

module rv_core_properties (
  input logic                    clk,
  input logic                    rst,
  input logic                    issue_ready_o,
  input logic                    wb_valid_o,
  input logic [4:0]              wb_rd_o,
  input logic                    host_arready_o,
  input logic [rv_pkg::XLEN-1:0] host_rdata_o,
  input logic                    host_rvalid_o,
  input logic                    host_rready_i
);

  a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    host_rvalid_o && !host_rready_i |=> host_rvalid_o && $stable(host_rdata_o))
    else $error("host R response dropped or changed before rready");

  a_no_ar_pending: assert property (@(posedge clk) disable iff (rst)
    host_rvalid_o |-> !host_arready_o)
    else $error("host arready high while a response is pending");

  a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
    wb_valid_o |-> wb_rd_o != 5'd0)
    else $error("writeback to x0");

  // First edge after reset release
  a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> issue_ready_o)
    else $error("issue_ready_o low right after reset");

endmodule

`default_nettype wire

// File: verif/rv_core_tb.sv
`default_nettype none
`timescale 1ns/100ps

module rv_core_tb;
  import rv_pkg::*;

  localparam int N_ALU     = 60;
  localparam int N_CHAIN   = 40;
  localparam int N_ST      = 40;
  localparam int N_LD      = 30;
  localparam int N_MIX     = 40;
  localparam int N_HOST    = 20;
  localparam int N_OPS     = N_ALU + N_CHAIN + 2 * N_ST + 2 * N_LD + N_MIX + N_HOST + 5;
  localparam int DRIVE_DLY = 5;

  logic              clk = 1'b0;
  logic              rst;
  logic              issue_valid_i;
  logic [ILEN-1:0]   issue_instr_i;
  logic              issue_ready_o;
  logic              wb_valid_o;
  logic [4:0]        wb_rd_o;
  logic [XLEN-1:0]   wb_data_o;
  logic [MEM_AW+1:0] host_araddr_i;
  logic              host_arvalid_i;
  logic              host_arready_o;
  logic [XLEN-1:0]   host_rdata_o;
  logic [1:0]        host_rresp_o;
  logic              host_rvalid_o;
  logic              host_rready_i;

  logic [31:0] regs_m [32];
  logic [7:0]  mem_m [1024];  // Byte view of the data memory
  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_data_q [$];
  logic [31:0] rng_state = 32'd15790;
  int          errors = 0;
  int          checks = 0;
  int          stall_cycles = 0;
  int          wb_pushed = 0;
  int          wb_seen = 0;

  rv_core_top i_rv_core_top (.*);

  bind rv_core_top rv_core_properties i_rv_core_properties (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'(next_rand() % 32);
  endfunction

  function automatic logic [4:0] rand_reg_nz();
    return 5'(1 + next_rand() % 31);
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] rand_alu(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic allow_lui);
    logic [31:0] r;
    logic [2:0]  f3;
    logic        alt;
    r   = next_rand();
    f3  = r[2:0];
    alt = r[3] && (f3 == 3'b000 || f3 == 3'b101);  // sub and sra
    if (allow_lui && r[5:4] == 2'd3) return {r[31:12], rd, OPC_LUI};
    if (!r[5]) return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    if (f3 == 3'b001 || f3 == 3'b101) begin
      return enc_i({1'b0, alt, 5'b0, r[24:20]}, rs1, f3, rd, OPC_OP_IMM);  // Shift amount
    end
    return enc_i(r[31:20], rs1, f3, rd, OPC_OP_IMM);
  endfunction

  // Aligned store below limit, x0 base
  function automatic logic [31:0] rand_store(input int limit);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [9:0]  addr;
    r = next_rand();
    case (r[1:0])
      2'd0:    f3 = w_b;
      2'd1:    f3 = w_h;
      default: f3 = w_w;
    endcase
    addr = 10'(r[31:8] % limit);
    if (f3 == w_h) addr[0] = 1'b0;
    if (f3 == w_w) addr[1:0] = 2'b00;
    return enc_s({2'b00, addr}, r[7:3], 5'd0, f3);
  endfunction

  function automatic logic [31:0] rand_load(input logic [4:0] rd);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [9:0]  addr;
    r = next_rand();
    case (r % 5)
      0:       f3 = w_b;
      1:       f3 = w_bu;
      2:       f3 = w_h;
      3:       f3 = w_hu;
      default: f3 = w_w;
    endcase
    addr = r[17:8];
    if (f3[1:0] == 2'b01) addr[0] = 1'b0;
    if (f3 == w_w) addr[1:0] = 2'b00;
    return enc_i({2'b00, addr}, 5'd0, f3, rd, OPC_LOAD);
  endfunction

  function automatic logic [31:0] word_at(input logic [7:0] w);
    return {mem_m[{w, 2'd3}], mem_m[{w, 2'd2}], mem_m[{w, 2'd1}], mem_m[{w, 2'd0}]};
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: begin
        if (alt) return a - b;
        return a + b;
      end
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101: begin
        if (alt) return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] load_model(input logic [2:0] f3, input logic [9:0] addr);
    logic [7:0]  b0;
    logic [15:0] h0;
    b0 = mem_m[addr];
    h0 = {mem_m[10'(addr + 1)], mem_m[addr]};  // Little endian
    case (f3)
      3'b000:  return {{24{b0[7]}}, b0};
      3'b100:  return {24'b0, b0};
      3'b001:  return {{16{h0[15]}}, h0};
      3'b101:  return {16'b0, h0};
      default: return word_at(addr[9:2]);
    endcase
  endfunction

  // Executes one accepted instruction in program order
  task automatic model_exec(input logic [31:0] ins);
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [9:0]  addr;
    logic        wr;
    rd  = ins[11:7];
    f3  = ins[14:12];
    a   = regs_m[ins[19:15]];
    b   = regs_m[ins[24:20]];
    wr  = 1'b1;
    res = '0;
    case (ins[6:0])
      OPC_OP:     res = alu_model(f3, ins[30], a, b);
      OPC_OP_IMM: res = alu_model(f3, ins[30] && f3 == 3'b101, a, {{20{ins[31]}}, ins[31:20]});
      OPC_LUI:    res = {ins[31:12], 12'b0};
      OPC_LOAD: begin
        addr = 10'(a + {{20{ins[31]}}, ins[31:20]});
        res  = load_model(f3, addr);
      end
      OPC_STORE: begin
        addr = 10'(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
        wr   = 1'b0;
        for (int k = 0; k < 4; k++) begin
          if (k < (1 << f3[1:0])) mem_m[10'(addr + k)] = b[8*k +: 8];
        end
      end
      default: wr = 1'b0;
    endcase
    if (wr && rd != 5'd0) begin
      regs_m[rd] = res;
      exp_rd_q.push_back(rd);
      exp_data_q.push_back(res);
      wb_pushed++;
    end
  endtask

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic issue(input logic [31:0] ins);
    issue_valid_i = 1'b1;
    issue_instr_i = ins;
    @(negedge clk);
    while (!issue_ready_o) begin
      stall_cycles++;
      @(negedge clk);
    end
    @(posedge clk);
    model_exec(ins);
    #DRIVE_DLY;
    issue_valid_i = 1'b0;
  endtask

  task automatic host_read(input logic [9:0] addr, input int dly);
    logic [31:0] exp;
    host_araddr_i  = addr;
    host_arvalid_i = 1'b1;
    @(negedge clk);
    while (!host_arready_o) @(negedge clk);
    @(posedge clk);
    exp = word_at(addr[9:2]);
    #DRIVE_DLY;
    host_arvalid_i = 1'b0;
    repeat (dly) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
    host_rready_i = 1'b1;
    @(negedge clk);
    check_equal(32'(host_rvalid_o), 32'd1, "host rvalid");
    check_equal(host_rdata_o, exp, "host rdata");
    check_equal(32'(host_rresp_o), 32'd0, "host rresp");  // OKAY
    @(posedge clk);
    #DRIVE_DLY;
    host_rready_i = 1'b0;
  endtask

  // Marker write, then wait until every expected writeback arrived
  task automatic wait_drain();
    issue(enc_i(12'd1, 5'd0, 3'b000, 5'd31, OPC_OP_IMM));
    while (exp_rd_q.size() != 0) @(negedge clk);
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    $display("test %0d %s: %s, %0d errors", num, name,
             (errors == errs_before) ? "ok" : "failed", errors - errs_before);
  endtask

  always @(negedge clk) begin
    if (!rst && wb_valid_o) begin
      wb_seen++;
      if (exp_rd_q.size() == 0) begin
        errors++;
        $display("Writeback to x%0d at %0t arrived with no instruction expected",
                 wb_rd_o, $time);
      end else begin
        check_equal(32'(wb_rd_o), 32'(exp_rd_q.pop_front()), "writeback rd");
        check_equal(wb_data_o, exp_data_q.pop_front(), "writeback data");
      end
    end
  end

  initial begin
    repeat (20 * N_OPS + 200) @(posedge clk);
    $display("Run timed out: not finished within %0d cycles", 20 * N_OPS + 200);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    logic [31:0] ins;
    logic [4:0]  rds [$];
    logic [7:0]  touched [$];
    logic [7:0]  upper [$];
    logic [9:0]  host_addr [N_HOST];
    int          host_dly [N_HOST];
    logic [4:0]  src1;
    logic [4:0]  src2;
    logic [4:0]  rd;
    logic [11:0] simm;
    int          e0;
    int          s0;
    rst            = 1'b1;
    issue_valid_i  = 1'b0;
    issue_instr_i  = '0;
    host_araddr_i  = '0;
    host_arvalid_i = 1'b0;
    host_rready_i  = 1'b0;
    for (int i = 0; i < 32; i++) regs_m[i] = '0;
    for (int i = 0; i < 1024; i++) mem_m[i] = '0;
    repeat (2) @(posedge clk);
    #DRIVE_DLY;
    rst = 1'b0;

    e0 = errors;
    for (int i = 0; i < N_ALU; i++) begin
      issue(rand_alu(rand_reg(), rand_reg(), rand_reg(), 1'b1));
    end
    wait_drain();
    report_test(1, "random ALU and LUI", e0);

    e0 = errors;
    for (int i = 0; i < N_CHAIN; i++) begin
      src1 = rand_reg();
      src2 = rand_reg();
      if (rds.size() >= 2) begin  // Distance 1 and 2 on the two ports
        if (next_rand() & 32'd1) begin
          src1 = rds[rds.size() - 1];
          src2 = rds[rds.size() - 2];
        end else begin
          src1 = rds[rds.size() - 2];
          src2 = rds[rds.size() - 1];
        end
      end
      rd = rand_reg_nz();
      rds.push_back(rd);
      issue(rand_alu(rd, src1, src2, 1'b0));
    end
    wait_drain();
    report_test(2, "dependent chains", e0);

    e0 = errors;
    for (int i = 0; i < N_ST; i++) begin
      ins  = rand_store(1024);
      simm = {ins[31:25], ins[11:7]};
      touched.push_back(simm[9:2]);
      issue(ins);
    end
    wait_drain();
    foreach (touched[i]) host_read({touched[i], 2'b00}, 0);
    report_test(3, "stores and host reads", e0);

    e0 = errors;
    s0 = stall_cycles;
    for (int i = 0; i < N_LD; i++) begin
      rd = rand_reg_nz();
      issue(rand_load(rd));
      issue({7'b0, rand_reg(), rd, 3'b000, rand_reg_nz(), OPC_OP});  // Uses the load result
    end
    check_equal(32'(stall_cycles - s0), 32'(N_LD), "load-use stall cycles");
    wait_drain();
    report_test(4, "load-use", e0);

    e0 = errors;
    foreach (touched[i]) begin
      if (touched[i][7]) upper.push_back(touched[i]);
    end
    // Upper half words written in test 3, the stores below stay in the lower half
    for (int i = 0; i < N_HOST; i++) begin
      if (upper.size() != 0) begin
        host_addr[i] = {upper[next_rand() % upper.size()], 2'b00};
      end else begin
        host_addr[i] = 10'(512 + 4 * (next_rand() % 128));
      end
      host_dly[i] = next_rand() % 4;
    end
    fork
      begin
        for (int i = 0; i < N_MIX; i++) begin
          case (next_rand() % 3)
            0:       issue(rand_alu(rand_reg(), rand_reg(), rand_reg(), 1'b1));
            1:       issue(rand_store(512));
            default: issue(rand_load(rand_reg_nz()));
          endcase
        end
      end
      begin
        for (int i = 0; i < N_HOST; i++) host_read(host_addr[i], host_dly[i]);
      end
    join
    wait_drain();
    report_test(5, "host reads under traffic", e0);

    check_equal(32'(wb_seen), 32'(wb_pushed), "writeback count");
    $display("tests run: 5, checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/rv_core_top.sv
`default_nettype none
`timescale 1ns/100ps

module rv_core_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      issue_valid_i,
  input  logic [rv_pkg::ILEN-1:0]   issue_instr_i,
  output logic                      issue_ready_o,
  output logic                      wb_valid_o,
  output logic [4:0]                wb_rd_o,
  output logic [rv_pkg::XLEN-1:0]   wb_data_o,
  input  logic [rv_pkg::MEM_AW+1:0] host_araddr_i,
  input  logic                      host_arvalid_i,
  output logic                      host_arready_o,
  output logic [rv_pkg::XLEN-1:0]   host_rdata_o,
  output logic [1:0]                host_rresp_o,
  output logic                      host_rvalid_o,
  input  logic                      host_rready_i
);
  import rv_pkg::*;

  logic [4:0]        rs1_idx, rs2_idx;
  logic [XLEN-1:0]   rs1_data, rs2_data;
  logic              mem_stall;

  logic              ex_valid;
  rv_opcode_e        ex_opcode;
  rv_aluop_e         ex_aluop;
  rv_width_e         ex_width;
  logic [4:0]        ex_rd, ex_rs1, ex_rs2;
  logic [XLEN-1:0]   ex_rs1_val, ex_rs2_val, ex_imm;

  logic              exm_valid;
  rv_opcode_e        exm_opcode;
  rv_width_e         exm_width;
  logic [4:0]        exm_rd;
  logic [XLEN-1:0]   exm_alu, exm_store;
  logic [3:0]        exm_be;

  logic              mem_req, mem_we;
  logic [MEM_AW-1:0] mem_addr;
  logic [3:0]        mem_be;
  logic [XLEN-1:0]   mem_wdata, mem_rdata;

  rv_regfile i_rv_regfile (
    .clk, .rst,
    .rs1_idx_i (rs1_idx),    .rs2_idx_i (rs2_idx),
    .rs1_data_o (rs1_data),  .rs2_data_o (rs2_data),
    .wr_en_i (wb_valid_o),   .wr_idx_i (wb_rd_o),     .wr_data_i (wb_data_o)
  );

  rv_decode i_rv_decode (
    .clk, .rst, .issue_valid_i, .issue_instr_i, .issue_ready_o,
    .rs1_idx_o (rs1_idx),    .rs2_idx_o (rs2_idx),
    .rs1_data_i (rs1_data),  .rs2_data_i (rs2_data),  .mem_stall_i (mem_stall),
    .ex_valid_o (ex_valid),  .ex_opcode_o (ex_opcode), .ex_aluop_o (ex_aluop),
    .ex_width_o (ex_width),  .ex_rd_o (ex_rd),         .ex_rs1_o (ex_rs1),
    .ex_rs2_o (ex_rs2),      .ex_rs1_val_o (ex_rs1_val), .ex_rs2_val_o (ex_rs2_val),
    .ex_imm_o (ex_imm)
  );

  rv_execute i_rv_execute (
    .clk, .rst, .mem_stall_i (mem_stall),
    .ex_valid_i (ex_valid),  .ex_opcode_i (ex_opcode), .ex_aluop_i (ex_aluop),
    .ex_width_i (ex_width),  .ex_rd_i (ex_rd),         .ex_rs1_i (ex_rs1),
    .ex_rs2_i (ex_rs2),      .ex_rs1_val_i (ex_rs1_val), .ex_rs2_val_i (ex_rs2_val),
    .ex_imm_i (ex_imm),
    .fwd_mem_valid_i (wb_valid_o), .fwd_mem_rd_i (wb_rd_o), .fwd_mem_data_i (wb_data_o),
    .mem_valid_o (exm_valid), .mem_opcode_o (exm_opcode), .mem_width_o (exm_width),
    .mem_rd_o (exm_rd),      .mem_alu_o (exm_alu),     .mem_store_o (exm_store),
    .mem_be_o (exm_be)
  );

  rv_mem_access i_rv_mem_access (
    .clk, .rst,
    .mem_valid_i (exm_valid), .mem_opcode_i (exm_opcode), .mem_width_i (exm_width),
    .mem_rd_i (exm_rd),      .mem_alu_i (exm_alu),     .mem_store_i (exm_store),
    .mem_be_i (exm_be),
    .mem_req_o (mem_req),    .mem_we_o (mem_we),       .mem_addr_o (mem_addr),
    .mem_be_o (mem_be),      .mem_wdata_o (mem_wdata), .mem_rdata_i (mem_rdata),
    .mem_stall_i (mem_stall),
    .wb_valid_o, .wb_rd_o, .wb_data_o
  );

  rv_data_mem i_rv_data_mem (
    .clk, .rst,
    .mem_req_i (mem_req),    .mem_we_i (mem_we),       .mem_addr_i (mem_addr),
    .mem_be_i (mem_be),      .mem_wdata_i (mem_wdata), .mem_rdata_o (mem_rdata),
    .mem_stall_o (mem_stall),
    .host_araddr_i, .host_arvalid_i, .host_arready_o,
    .host_rdata_o, .host_rresp_o, .host_rvalid_o, .host_rready_i
  );

endmodule

`default_nettype wire

// File: verilog/rv_data_mem.sv
`default_nettype none
`timescale 1ns/100ps

module rv_data_mem (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mem_req_i,
  input  logic                      mem_we_i,
  input  logic [rv_pkg::MEM_AW-1:0] mem_addr_i,
  input  logic [3:0]                mem_be_i,
  input  logic [rv_pkg::XLEN-1:0]   mem_wdata_i,
  output logic [rv_pkg::XLEN-1:0]   mem_rdata_o,
  output logic                      mem_stall_o,
  input  logic [rv_pkg::MEM_AW+1:0] host_araddr_i,
  input  logic                      host_arvalid_i,
  output logic                      host_arready_o,
  output logic [rv_pkg::XLEN-1:0]   host_rdata_o,
  output logic [1:0]                host_rresp_o,
  output logic                      host_rvalid_o,
  input  logic                      host_rready_i
);
  import rv_pkg::*;

  logic [XLEN-1:0] mem [2**MEM_AW];
  logic            last_host;  // Host won the previous grant
  logic            host_req;
  logic            gnt_pipe, gnt_host;

  assign host_req = host_arvalid_i && !host_rvalid_o;  // No new AR while R pending
  assign gnt_pipe = mem_req_i && !(host_req && !last_host);
  assign gnt_host = host_req && !gnt_pipe;

  assign mem_stall_o    = mem_req_i && !gnt_pipe;
  assign host_arready_o = gnt_host;
  assign host_rresp_o   = RESP_OKAY;
  assign mem_rdata_o    = mem[mem_addr_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**MEM_AW; i++) begin
        mem[i] <= '0;
      end
    end else if (gnt_pipe && mem_we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_be_i[b]) mem[mem_addr_i][8*b +: 8] <= mem_wdata_i[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      last_host     <= 1'b0;
      host_rvalid_o <= 1'b0;
    end else begin
      if (gnt_host) begin
        last_host <= 1'b1;
      end else if (gnt_pipe) begin
        last_host <= 1'b0;
      end
      if (gnt_host) begin
        host_rvalid_o <= 1'b1;
      end else if (host_rready_i) begin
        host_rvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (gnt_host) host_rdata_o <= mem[host_araddr_i[MEM_AW+1:2]];
  end

endmodule

`default_nettype wire

// File: verilog/rv_decode.sv
`default_nettype none
`timescale 1ns/100ps

module rv_decode (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    issue_valid_i,
  input  logic [rv_pkg::ILEN-1:0] issue_instr_i,
  output logic                    issue_ready_o,
  output logic [4:0]              rs1_idx_o,
  output logic [4:0]              rs2_idx_o,
  input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
  input  logic                    mem_stall_i,
  output logic                    ex_valid_o,
  output rv_pkg::rv_opcode_e      ex_opcode_o,
  output rv_pkg::rv_aluop_e       ex_aluop_o,
  output rv_pkg::rv_width_e       ex_width_o,
  output logic [4:0]              ex_rd_o,
  output logic [4:0]              ex_rs1_o,
  output logic [4:0]              ex_rs2_o,
  output logic [rv_pkg::XLEN-1:0] ex_rs1_val_o,
  output logic [rv_pkg::XLEN-1:0] ex_rs2_val_o,
  output logic [rv_pkg::XLEN-1:0] ex_imm_o
);
  import rv_pkg::*;

  rv_opcode_e      dec_op;
  rv_aluop_e       dec_alu;
  logic [4:0]      dec_rd, dec_rs1, dec_rs2;
  logic [XLEN-1:0] dec_imm;
  logic            load_use;
  logic            fire;

  function automatic rv_aluop_e alu_sel(input logic [2:0] f3, input logic b30,
                                        input logic is_reg);
    case (f3)
      3'b000:  return (is_reg && b30) ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return b30 ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_comb begin
    dec_op  = op_none;
    dec_alu = alu_add;  // Address add for loads, stores and LUI
    dec_rd  = issue_instr_i[11:7];
    dec_rs1 = issue_instr_i[19:15];
    dec_rs2 = 5'd0;
    dec_imm = {{20{issue_instr_i[31]}}, issue_instr_i[31:20]};
    case (issue_instr_i[6:0])
      OPC_OP: begin
        dec_op  = op_reg;
        dec_rs2 = issue_instr_i[24:20];
        dec_alu = alu_sel(issue_instr_i[14:12], issue_instr_i[30], 1'b1);
      end
      OPC_OP_IMM: begin
        dec_op  = op_imm;
        dec_alu = alu_sel(issue_instr_i[14:12], issue_instr_i[30], 1'b0);
      end
      OPC_LUI: begin
        dec_op  = op_lui;
        dec_rs1 = 5'd0;  // x0 plus upper immediate
        dec_imm = {issue_instr_i[31:12], 12'b0};
      end
      OPC_LOAD: dec_op = op_load;
      OPC_STORE: begin
        dec_op  = op_store;
        dec_rd  = 5'd0;
        dec_rs2 = issue_instr_i[24:20];
        dec_imm = {{20{issue_instr_i[31]}}, issue_instr_i[31:25], issue_instr_i[11:7]};
      end
      default: begin
        dec_rd  = 5'd0;  // Unsupported, never writes back
        dec_rs1 = 5'd0;
      end
    endcase
  end

  assign load_use = ex_valid_o && ex_opcode_o == op_load && ex_rd_o != 5'd0 &&
                    (ex_rd_o == dec_rs1 || ex_rd_o == dec_rs2);
  assign issue_ready_o = !mem_stall_i && !load_use;
  assign fire = issue_valid_i && issue_ready_o;

  // While held, re-read the held sources so a retiring write is not missed
  assign rs1_idx_o = mem_stall_i ? ex_rs1_o : dec_rs1;
  assign rs2_idx_o = mem_stall_i ? ex_rs2_o : dec_rs2;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid_o  <= 1'b0;
      ex_opcode_o <= op_none;
    end else if (!mem_stall_i) begin
      ex_valid_o  <= fire;  // Bubble on load-use
      ex_opcode_o <= fire ? dec_op : op_none;
    end
  end

  always_ff @(posedge clk) begin
    ex_rs1_val_o <= rs1_data_i;
    ex_rs2_val_o <= rs2_data_i;
    if (!mem_stall_i) begin
      ex_aluop_o <= dec_alu;
      ex_width_o <= rv_width_e'(issue_instr_i[14:12]);
      ex_rd_o    <= dec_rd;
      ex_rs1_o   <= dec_rs1;
      ex_rs2_o   <= dec_rs2;
      ex_imm_o   <= dec_imm;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rv_execute.sv
`default_nettype none
`timescale 1ns/100ps

module rv_execute (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    mem_stall_i,
  input  logic                    ex_valid_i,
  input  rv_pkg::rv_opcode_e      ex_opcode_i,
  input  rv_pkg::rv_aluop_e       ex_aluop_i,
  input  rv_pkg::rv_width_e       ex_width_i,
  input  logic [4:0]              ex_rd_i,
  input  logic [4:0]              ex_rs1_i,
  input  logic [4:0]              ex_rs2_i,
  input  logic [rv_pkg::XLEN-1:0] ex_rs1_val_i,
  input  logic [rv_pkg::XLEN-1:0] ex_rs2_val_i,
  input  logic [rv_pkg::XLEN-1:0] ex_imm_i,
  input  logic                    fwd_mem_valid_i,
  input  logic [4:0]              fwd_mem_rd_i,
  input  logic [rv_pkg::XLEN-1:0] fwd_mem_data_i,
  output logic                    mem_valid_o,
  output rv_pkg::rv_opcode_e      mem_opcode_o,
  output rv_pkg::rv_width_e       mem_width_o,
  output logic [4:0]              mem_rd_o,
  output logic [rv_pkg::XLEN-1:0] mem_alu_o,
  output logic [rv_pkg::XLEN-1:0] mem_store_o,
  output logic [3:0]              mem_be_o
);
  import rv_pkg::*;

  logic            exm_fwd_ok;
  logic [XLEN-1:0] op_a, rs2_fwd, op_b;
  logic [XLEN-1:0] alu_res;
  logic [3:0]      be;

  // Load data is not ready in EX/MEM; decode stalls for that case
  assign exm_fwd_ok = mem_valid_o && mem_opcode_o != op_load;

  always_comb begin
    op_a = ex_rs1_val_i;
    if (ex_rs1_i != 5'd0 && exm_fwd_ok && mem_rd_o == ex_rs1_i) begin
      op_a = mem_alu_o;  // From EX/MEM
    end else if (ex_rs1_i != 5'd0 && fwd_mem_valid_i && fwd_mem_rd_i == ex_rs1_i) begin
      op_a = fwd_mem_data_i;  // From MEM/WB
    end

    rs2_fwd = ex_rs2_val_i;
    if (ex_rs2_i != 5'd0 && exm_fwd_ok && mem_rd_o == ex_rs2_i) begin
      rs2_fwd = mem_alu_o;
    end else if (ex_rs2_i != 5'd0 && fwd_mem_valid_i && fwd_mem_rd_i == ex_rs2_i) begin
      rs2_fwd = fwd_mem_data_i;
    end
  end

  assign op_b = (ex_opcode_i == op_reg) ? rs2_fwd : ex_imm_i;

  always_comb begin
    case (ex_aluop_i)
      alu_add:  alu_res = op_a + op_b;
      alu_sub:  alu_res = op_a - op_b;
      alu_sll:  alu_res = op_a << op_b[4:0];
      alu_slt:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      alu_xor:  alu_res = op_a ^ op_b;
      alu_srl:  alu_res = op_a >> op_b[4:0];
      alu_sra:  alu_res = $signed(op_a) >>> op_b[4:0];
      alu_or:   alu_res = op_a | op_b;
      alu_and:  alu_res = op_a & op_b;
      default:  alu_res = '0;
    endcase
  end

  // Lane enables from access width and low address bits
  always_comb begin
    be = 4'b0000;
    if (ex_opcode_i == op_load || ex_opcode_i == op_store) begin
      case (ex_width_i)
        w_b, w_bu: be = 4'b0001 << alu_res[1:0];
        w_h, w_hu: be = 4'b0011 << alu_res[1:0];
        default:   be = 4'b1111;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid_o  <= 1'b0;
      mem_opcode_o <= op_none;
    end else if (!mem_stall_i) begin
      mem_valid_o  <= ex_valid_i;
      mem_opcode_o <= ex_opcode_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_stall_i) begin
      mem_width_o <= ex_width_i;
      mem_rd_o    <= ex_rd_i;
      mem_alu_o   <= alu_res;
      mem_store_o <= rs2_fwd;
      mem_be_o    <= be;
    end
  end

endmodule

`default_nettype wire

// File: verilog/rv_mem_access.sv
`default_nettype none
`timescale 1ns/100ps

module rv_mem_access (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mem_valid_i,
  input  rv_pkg::rv_opcode_e        mem_opcode_i,
  input  rv_pkg::rv_width_e         mem_width_i,
  input  logic [4:0]                mem_rd_i,
  input  logic [rv_pkg::XLEN-1:0]   mem_alu_i,
  input  logic [rv_pkg::XLEN-1:0]   mem_store_i,
  input  logic [3:0]                mem_be_i,
  output logic                      mem_req_o,
  output logic                      mem_we_o,
  output logic [rv_pkg::MEM_AW-1:0] mem_addr_o,
  output logic [3:0]                mem_be_o,
  output logic [rv_pkg::XLEN-1:0]   mem_wdata_o,
  input  logic [rv_pkg::XLEN-1:0]   mem_rdata_i,
  input  logic                      mem_stall_i,
  output logic                      wb_valid_o,
  output logic [4:0]                wb_rd_o,
  output logic [rv_pkg::XLEN-1:0]   wb_data_o
);
  import rv_pkg::*;

  logic            is_load;
  logic [XLEN-1:0] lane;
  logic [XLEN-1:0] ld_data;

  assign is_load    = mem_opcode_i == op_load;
  assign mem_req_o  = mem_valid_i && (is_load || mem_opcode_i == op_store);
  assign mem_we_o   = mem_valid_i && mem_opcode_i == op_store;
  assign mem_addr_o = mem_alu_i[MEM_AW+1:2];  // Word index
  assign mem_be_o   = mem_be_i & {4{mem_we_o}};

  always_comb begin
    case (mem_width_i)
      w_b, w_bu: mem_wdata_o = {4{mem_store_i[7:0]}};
      w_h, w_hu: mem_wdata_o = {2{mem_store_i[15:0]}};
      default:   mem_wdata_o = mem_store_i;
    endcase
  end

  assign lane = mem_rdata_i >> {mem_alu_i[1:0], 3'b000};  // Addressed lane to bit 0

  always_comb begin
    case (mem_width_i)
      w_b:     ld_data = {{24{lane[7]}}, lane[7:0]};
      w_bu:    ld_data = {24'b0, lane[7:0]};
      w_h:     ld_data = {{16{lane[15]}}, lane[15:0]};
      w_hu:    ld_data = {16'b0, lane[15:0]};
      default: ld_data = mem_rdata_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= mem_valid_i && mem_rd_i != 5'd0 && !mem_stall_i;  // Bubble until granted
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_o   <= mem_rd_i;
    wb_data_o <= is_load ? ld_data : mem_alu_i;
  end

endmodule

`default_nettype wire

// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN = 32;
  localparam int ILEN = 32;
  localparam int MEM_AW = 8;  // 256 words

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef enum logic [2:0] {
    op_none,
    op_reg,
    op_imm,
    op_lui,
    op_load,
    op_store
  } rv_opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } rv_aluop_e;

  // Encoded as funct3 of loads and stores
  typedef enum logic [2:0] {
    w_b  = 3'b000,
    w_h  = 3'b001,
    w_w  = 3'b010,
    w_bu = 3'b100,
    w_hu = 3'b101
  } rv_width_e;

endpackage

`default_nettype wire

// File: verilog/rv_regfile.sv
`default_nettype none
`timescale 1ns/100ps

module rv_regfile (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [4:0]              rs1_idx_i,
  input  logic [4:0]              rs2_idx_i,
  output logic [rv_pkg::XLEN-1:0] rs1_data_o,
  output logic [rv_pkg::XLEN-1:0] rs2_data_o,
  input  logic                    wr_en_i,
  input  logic [4:0]              wr_idx_i,
  input  logic [rv_pkg::XLEN-1:0] wr_data_i
);
  import rv_pkg::*;

  logic [XLEN-1:0] regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && wr_idx_i != 5'd0) begin
      regs[wr_idx_i] <= wr_data_i;
    end
  end

  function automatic logic [XLEN-1:0] read_port(input logic [4:0] idx);
    if (idx == 5'd0) return '0;
    if (wr_en_i && wr_idx_i == idx) return wr_data_i;  // Write-first bypass
    return regs[idx];
  endfunction

  assign rs1_data_o = read_port(rs1_idx_i);
  assign rs2_data_o = read_port(rs2_idx_i);

endmodule

`default_nettype wire
